// File: ExecCore.sv
`timescale 1ns/10ps

module ExecCore #(
    parameter int NUM_UOPS = 2,
    parameter int NUM_WBS = 3,
    parameter int NUM_XUS = 3,
    parameter int NUM_ZC_FWDS = 2
) (
    input logic clk,
    input logic rst,

    input logic uopValid [NUM_UOPS-1:0],
    input uopPkg::R_UOp uop [NUM_UOPS-1:0],
    input logic wbStall [NUM_UOPS-1:0],

    input logic invalidate,
    input regPkg::SqN invalidateSqN,

    input logic lsuHasResult,
    input regPkg::RES_UOp lsuResult,

    output uopPkg::EX_UOp exUop [NUM_UOPS-1:0],
    output logic [NUM_XUS-1:0] enableXU [NUM_UOPS-1:0],

    // Integer lane 0, integer lane 1, multiplier
    output logic wbHasResult [NUM_WBS-1:0],
    output regPkg::RES_UOp wbUOp [NUM_WBS-1:0]
);
    import regPkg::*;
    import uopPkg::*;

    regPkg::Tag rfReadAddr [2*NUM_UOPS-1:0];
    logic [31:0] rfReadData [2*NUM_UOPS-1:0];

    ZcFwd zcFwd [NUM_ZC_FWDS-1:0];
    logic intHasResult [NUM_UOPS-1:0];
    RES_UOp intUOp [NUM_UOPS-1:0];
    logic mulHasResult;
    RES_UOp mulUOp;

    // Buses seen by the register file and the Load snoop
    logic wbValid [NUM_WBS-1:0];
    RES_UOp wbBus [NUM_WBS-1:0];

    // Lane 1 ALU and multiplier share one register write port
    always_comb begin
        wbValid[0] = intHasResult[0];
        wbBus[0] = intUOp[0];
        wbValid[1] = intHasResult[1] || mulHasResult;
        wbBus[1] = mulHasResult ? mulUOp : intUOp[1];
        wbValid[NUM_WBS-1] = lsuHasResult;
        wbBus[NUM_WBS-1] = lsuResult;

        wbHasResult[0] = intHasResult[0];
        wbUOp[0] = intUOp[0];
        wbHasResult[1] = intHasResult[1];
        wbUOp[1] = intUOp[1];
        wbHasResult[2] = mulHasResult;
        wbUOp[2] = mulUOp;
    end

    RegFile #(
        .NUM_UOPS(NUM_UOPS),
        .NUM_WBS(NUM_WBS)
    ) regFile (
        .clk(clk),
        .rst(rst),
        .readAddr(rfReadAddr),
        .readData(rfReadData),
        .wbHasResult(wbValid),
        .wbUOp(wbBus)
    );

    Load #(
        .NUM_UOPS(NUM_UOPS),
        .NUM_WBS(NUM_WBS),
        .NUM_XUS(NUM_XUS),
        .NUM_ZC_FWDS(NUM_ZC_FWDS)
    ) load (
        .clk(clk),
        .rst(rst),
        .wbStall(wbStall),
        .uopValid(uopValid),
        .uop(uop),
        .wbHasResult(wbValid),
        .wbUOp(wbBus),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .zcFwd(zcFwd),
        .rfReadAddr(rfReadAddr),
        .rfReadData(rfReadData),
        .enableXU(enableXU),
        .exUop(exUop)
    );

    for (genvar i = 0; i < NUM_UOPS; i++) begin : genInt
        IntUnit intUnit (
            .clk(clk),
            .rst(rst),
            .invalidate(invalidate),
            .invalidateSqN(invalidateSqN),
            .en(enableXU[i][FU_INT]),
            .exUop(exUop[i]),
            .zcFwd(zcFwd[i]),
            .wbHasResult(intHasResult[i]),
            .wbUOp(intUOp[i])
        );
    end

    MulUnit mulUnit (
        .clk(clk),
        .rst(rst),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .en(enableXU[1][FU_MUL]),
        .exUop(exUop[1]),
        .wbHasResult(mulHasResult),
        .wbUOp(mulUOp)
    );

    // Issue must not put an ALU op on lane 1 right behind a multiply
    assert property (@(posedge clk) disable iff (rst)
        !(intHasResult[1] && mulHasResult))
        else $error("Lane 1 ALU and multiplier write back together");

endmodule

// File: IntUnit.sv
`timescale 1ns/10ps

module IntUnit (
    input logic clk,
    input logic rst,

    input logic invalidate,
    input regPkg::SqN invalidateSqN,

    input logic en,
    input uopPkg::EX_UOp exUop,

    output regPkg::ZcFwd zcFwd,

    output logic wbHasResult,
    output regPkg::RES_UOp wbUOp
);
    import regPkg::*;
    import uopPkg::*;

    logic [31:0] result;
    logic [4:0] shamt;

    assign shamt = exUop.srcB[4:0];

    always_comb begin
        case (exUop.opcode)
            ADD: result = exUop.srcA + exUop.srcB;
            SUB: result = exUop.srcA - exUop.srcB;
            AND: result = exUop.srcA & exUop.srcB;
            OR: result = exUop.srcA | exUop.srcB;
            XOR: result = exUop.srcA ^ exUop.srcB;
            SLT: result = {31'b0, $signed(exUop.srcA) < $signed(exUop.srcB)};
            SLTU: result = {31'b0, exUop.srcA < exUop.srcB};
            SLL: result = exUop.srcA << shamt;
            SRL: result = exUop.srcA >> shamt;
            SRA: result = $unsigned($signed(exUop.srcA) >>> shamt);
            // Immediate arrives already shifted into the upper bits
            LUI: result = exUop.srcB;
            default: result = '0;
        endcase
    end

    // Same-cycle result back to Load for back-to-back dependents
    always_comb begin
        zcFwd.result = result;
        zcFwd.tag = exUop.tagDst;
        zcFwd.valid = en && exUop.valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbHasResult <= 1'b0;
        end else begin
            wbHasResult <= en && exUop.valid &&
                !(invalidate && isYounger(exUop.sqN, invalidateSqN));
        end
    end

    always_ff @(posedge clk) begin
        wbUOp.result <= result;
        wbUOp.tagDst <= exUop.tagDst;
        wbUOp.sqN <= exUop.sqN;
        wbUOp.nmDst <= exUop.nmDst;
    end

endmodule

// File: Load.sv
`timescale 1ns/10ps

module Load #(
    parameter int NUM_UOPS = 2,
    parameter int NUM_WBS = 3,
    parameter int NUM_XUS = 3,
    parameter int NUM_ZC_FWDS = 2
) (
    input logic clk,
    input logic rst,

    // Holds the lane output while the lane cannot write back
    input logic wbStall [NUM_UOPS-1:0],
    input logic uopValid [NUM_UOPS-1:0],
    input uopPkg::R_UOp uop [NUM_UOPS-1:0],

    input logic wbHasResult [NUM_WBS-1:0],
    input regPkg::RES_UOp wbUOp [NUM_WBS-1:0],

    input logic invalidate,
    input regPkg::SqN invalidateSqN,

    input regPkg::ZcFwd zcFwd [NUM_ZC_FWDS-1:0],

    output regPkg::Tag rfReadAddr [2*NUM_UOPS-1:0],
    input logic [31:0] rfReadData [2*NUM_UOPS-1:0],

    output logic [NUM_XUS-1:0] enableXU [NUM_UOPS-1:0],
    output uopPkg::EX_UOp exUop [NUM_UOPS-1:0]
);
    import regPkg::*;
    import uopPkg::*;

    // Read port i carries operand A of lane i, port i+NUM_UOPS operand B
    logic [31:0] operand [2*NUM_UOPS-1:0];
    EX_UOp nextUop [NUM_UOPS-1:0];
    logic accept [NUM_UOPS-1:0];

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            rfReadAddr[i] = uop[i].tagA;
            rfReadAddr[i+NUM_UOPS] = uop[i].tagB;
        end
    end

    // Register file, then writeback buses, then zero-cycle forwards.
    // Within a kind the last match, the higher index, wins
    always_comb begin
        for (int p = 0; p < 2*NUM_UOPS; p++) begin
            operand[p] = rfReadData[p];
            // Tag 0 is the hardwired zero register
            if (rfReadAddr[p] != '0) begin
                for (int j = 0; j < NUM_WBS; j++) begin
                    if (wbHasResult[j] && wbUOp[j].tagDst == rfReadAddr[p]) begin
                        operand[p] = wbUOp[j].result;
                    end
                end
                for (int j = 0; j < NUM_ZC_FWDS; j++) begin
                    if (zcFwd[j].valid && zcFwd[j].tag == rfReadAddr[p]) begin
                        operand[p] = zcFwd[j].result;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            nextUop[i].srcA = uop[i].pcA ? uop[i].pc : operand[i];
            nextUop[i].srcB = uop[i].immB ? uop[i].imm : operand[i+NUM_UOPS];
            nextUop[i].imm = uop[i].imm;
            nextUop[i].pc = uop[i].pc;
            nextUop[i].sqN = uop[i].sqN;
            nextUop[i].tagDst = uop[i].tagDst;
            nextUop[i].nmDst = uop[i].nmDst;
            nextUop[i].opcode = uop[i].opcode;
            nextUop[i].loadSqN = uop[i].loadSqN;
            nextUop[i].storeSqN = uop[i].storeSqN;
            nextUop[i].valid = 1'b1;

            accept[i] = !wbStall[i] && uopValid[i] &&
                !(invalidate && isYounger(uop[i].sqN, invalidateSqN));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                exUop[i].valid <= 1'b0;
                enableXU[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (accept[i]) begin
                    exUop[i] <= nextUop[i];
                    enableXU[i] <= NUM_XUS'(1) << uop[i].fu;
                end else if (!wbStall[i] ||
                        (invalidate && isYounger(exUop[i].sqN, invalidateSqN))) begin
                    // A stalled micro-op still dies on a flush that hits it
                    exUop[i].valid <= 1'b0;
                    enableXU[i] <= '0;
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_UOPS; i++) begin : genLaneChecks
        assert property (@(posedge clk) disable iff (rst)
            exUop[i].valid |-> $onehot(enableXU[i]))
            else $error("Lane %0d enable is not one-hot", i);
    end

    // Only lane 1 has a multiplier behind it
    assert property (@(posedge clk) disable iff (rst)
        !(exUop[0].valid && enableXU[0][FU_MUL]))
        else $error("Multiply issued on lane 0");

endmodule

// File: MulUnit.sv
`timescale 1ns/10ps

module MulUnit (
    input logic clk,
    input logic rst,

    input logic invalidate,
    input regPkg::SqN invalidateSqN,

    input logic en,
    input uopPkg::EX_UOp exUop,

    output logic wbHasResult,
    output regPkg::RES_UOp wbUOp
);
    import regPkg::*;
    import uopPkg::*;

    typedef struct packed {
        SqN sqN;
        Tag tagDst;
        logic [4:0] nmDst;
        logic hi;
    } MulMeta;

    logic s1Valid;
    logic signed [63:0] s1Product;
    MulMeta s1Meta;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            wbHasResult <= 1'b0;
        end else begin
            s1Valid <= en && exUop.valid &&
                !(invalidate && isYounger(exUop.sqN, invalidateSqN));
            wbHasResult <= s1Valid &&
                !(invalidate && isYounger(s1Meta.sqN, invalidateSqN));
        end
    end

    always_ff @(posedge clk) begin
        s1Product <= $signed(exUop.srcA) * $signed(exUop.srcB);
        s1Meta.sqN <= exUop.sqN;
        s1Meta.tagDst <= exUop.tagDst;
        s1Meta.nmDst <= exUop.nmDst;
        s1Meta.hi <= (exUop.opcode == MUL_HI);

        wbUOp.result <= s1Meta.hi ? s1Product[63:32] : s1Product[31:0];
        wbUOp.tagDst <= s1Meta.tagDst;
        wbUOp.sqN <= s1Meta.sqN;
        wbUOp.nmDst <= s1Meta.nmDst;
    end

endmodule

// File: RegFile.sv
`timescale 1ns/10ps

module RegFile #(
    parameter int NUM_UOPS = 2,
    parameter int NUM_WBS = 3
) (
    input logic clk,
    input logic rst,

    input regPkg::Tag readAddr [2*NUM_UOPS-1:0],
    output logic [31:0] readData [2*NUM_UOPS-1:0],

    input logic wbHasResult [NUM_WBS-1:0],
    input regPkg::RES_UOp wbUOp [NUM_WBS-1:0]
);
    import regPkg::*;

    localparam int NUM_REGS = 1 << $bits(Tag);

    logic [31:0] regs [0:NUM_REGS-1];

    // No bypass since Load snoops the writeback buses in the write cycle
    always_comb begin
        for (int p = 0; p < 2*NUM_UOPS; p++) begin
            if (readAddr[p] == '0) begin
                readData[p] = '0;
            end else begin
                readData[p] = regs[readAddr[p]];
            end
        end
    end

    // Later ports overwrite earlier ones on a tag clash
    always_ff @(posedge clk) begin
        for (int j = 0; j < NUM_WBS; j++) begin
            if (wbHasResult[j] && wbUOp[j].tagDst != '0) begin
                regs[wbUOp[j].tagDst] <= wbUOp[j].result;
            end
        end
    end

    // Rename hands out each physical tag once, so writers never collide
    for (genvar j = 0; j < NUM_WBS; j++) begin : genPortA
        for (genvar k = j + 1; k < NUM_WBS; k++) begin : genPortB
            assert property (@(posedge clk) disable iff (rst)
                !(wbHasResult[j] && wbHasResult[k] &&
                  wbUOp[j].tagDst == wbUOp[k].tagDst && wbUOp[j].tagDst != '0))
                else $error("Two writebacks to tag %0d in one cycle", wbUOp[j].tagDst);
        end
    end

endmodule

// File: project.f
regPkg.sv
uopPkg.sv
RegFile.sv
Load.sv
IntUnit.sv
MulUnit.sv
ExecCore.sv
tbExecCore.sv

// File: regPkg.sv
package regPkg;

    // Physical register index
    typedef logic [5:0] Tag;

    // Sequence numbers wrap, so order is taken from the signed difference
    typedef logic [5:0] SqN;

    typedef struct packed {
        logic [31:0] result;
        Tag tagDst;
        SqN sqN;
        logic [4:0] nmDst;
    } RES_UOp;

    typedef struct packed {
        logic [31:0] result;
        Tag tag;
        logic valid;
    } ZcFwd;

    // True when sqN a lies after sqN b in program order
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

// File: tbExecCore.sv
`timescale 1ns/10ps

module tbExecCore;
    import regPkg::*;
    import uopPkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    // The five tests together run for about 50 cycles
    localparam int TEST_CYCLES = 70;
    localparam int MARGIN_CYCLES = 50;

    logic clk;
    logic rst;
    logic uopValid [1:0];
    R_UOp uop [1:0];
    logic wbStall [1:0];
    logic invalidate;
    SqN invalidateSqN;
    logic lsuHasResult;
    RES_UOp lsuResult;
    EX_UOp exUop [1:0];
    logic [2:0] enableXU [1:0];
    logic wbHasResult [2:0];
    RES_UOp wbUOp [2:0];

    integer seed = 46;
    int cyc = 0;
    SqN nextSqN = '0;
    logic [31:0] regVal [0:63];
    EX_UOp wantEx [1:0];
    logic [2:0] wantEn [1:0];
    // Expected writebacks per bus, with the cycle each one is due
    RES_UOp expQ [3][$];
    int dueQ [3][$];

    ExecCore dut (
        .clk(clk),
        .rst(rst),
        .uopValid(uopValid),
        .uop(uop),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .lsuHasResult(lsuHasResult),
        .lsuResult(lsuResult),
        .exUop(exUop),
        .enableXU(enableXU),
        .wbHasResult(wbHasResult),
        .wbUOp(wbUOp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic reportMismatch(input string msg);
        stopRun($sformatf("MISMATCH at %0t ns: %s", $time, msg));
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic checkRes(input RES_UOp got, input RES_UOp exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic checkExUop(input EX_UOp got, input logic [2:0] gotEn,
            input EX_UOp exp, input logic [2:0] expEn, input string what);
        if (exp.valid ? (got !== exp || gotEn !== expEn)
                : (got.valid !== 1'b0 || gotEn !== 3'b000)) begin
            reportMismatch($sformatf("%s got %h enable %b, expected %h enable %b",
                what, got, gotEn, exp, expEn));
        end
    endtask

    function automatic logic [31:0] expectedResult(FuncUnit fu, AluOp op,
            logic [31:0] a, logic [31:0] b);
        logic signed [63:0] prod;
        prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        if (fu == FU_MUL) begin
            return (op == MUL_HI) ? prod[63:32] : prod[31:0];
        end
        case (op)
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            OR: return a | b;
            XOR: return a ^ b;
            SLT: return {31'b0, $signed(a) < $signed(b)};
            SLTU: return {31'b0, a < b};
            SLL: return a << b[4:0];
            SRL: return a >> b[4:0];
            SRA: return $signed(a) >>> b[4:0];
            LUI: return b;
            default: return '0;
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
        uopValid[0] = 1'b0;
        uopValid[1] = 1'b0;
        invalidate = 1'b0;
        lsuHasResult = 1'b0;
    endtask

    // A dropped micro-op is killed by a flush and leaves no writeback
    task automatic issue(input int lane, input FuncUnit fu, input AluOp op,
            input Tag tagA, input Tag tagB, input Tag tagDst, input logic pcA,
            input logic immB, input logic [31:0] imm, input logic dropped);
        R_UOp u;
        logic [31:0] a;
        logic [31:0] b;
        RES_UOp r;
        int bus;
        u = '0;
        u.imm = imm;
        u.pc = 32'h0000_1000 + {24'b0, nextSqN, 2'b00};
        u.sqN = nextSqN;
        u.tagA = tagA;
        u.tagB = tagB;
        u.tagDst = tagDst;
        u.nmDst = tagDst[4:0];
        u.opcode = op;
        u.fu = fu;
        u.pcA = pcA;
        u.immB = immB;
        a = pcA ? u.pc : regVal[tagA];
        b = immB ? imm : regVal[tagB];
        wantEx[lane] = '{srcA: a, srcB: b, imm: imm, pc: u.pc, sqN: u.sqN,
            tagDst: tagDst, nmDst: u.nmDst, opcode: op, loadSqN: '0,
            storeSqN: '0, valid: 1'b1};
        wantEn[lane] = 3'b001 << fu;
        if (!dropped && fu != FU_LSU) begin
            r.result = expectedResult(fu, op, a, b);
            r.tagDst = tagDst;
            r.sqN = u.sqN;
            r.nmDst = u.nmDst;
            if (tagDst != '0) begin
                regVal[tagDst] = r.result;
            end
            bus = (fu == FU_MUL) ? 2 : lane;
            expQ[bus].push_back(r);
            dueQ[bus].push_back(cyc + ((fu == FU_MUL) ? 3 : 2));
        end
        uop[lane] = u;
        uopValid[lane] = 1'b1;
        nextSqN = nextSqN + 1'b1;
    endtask

    task automatic injectLsu(input Tag tagDst, input logic [31:0] value, input SqN sq);
        lsuResult = '{result: value, tagDst: tagDst, sqN: sq, nmDst: tagDst[4:0]};
        lsuHasResult = 1'b1;
        regVal[tagDst] = value;
    endtask

    task automatic flush(input SqN sq);
        invalidate = 1'b1;
        invalidateSqN = sq;
    endtask

    task automatic drain();
        while (expQ[0].size() + expQ[1].size() + expQ[2].size() > 0) begin
            tick();
        end
    endtask

    // Writeback monitor checks value and arrival cycle on every bus
    always @(negedge clk) begin
        if (!rst) begin
            for (int b = 0; b < 3; b++) begin
                if (wbHasResult[b]) begin
                    if (expQ[b].size() == 0) begin
                        stopRun($sformatf("Unexpected writeback on bus %0d for tag %0d",
                            b, wbUOp[b].tagDst));
                    end
                    if (dueQ[b][0] != cyc) begin
                        reportMismatch($sformatf("bus %0d wrote back in cycle %0d, due in %0d",
                            b, cyc, dueQ[b][0]));
                    end
                    checkRes(wbUOp[b], expQ[b][0], $sformatf("writeback bus %0d", b));
                    void'(expQ[b].pop_front());
                    void'(dueQ[b].pop_front());
                end else if (dueQ[b].size() > 0 && dueQ[b][0] <= cyc) begin
                    stopRun($sformatf("Writeback on bus %0d for tag %0d never arrived",
                        b, expQ[b][0].tagDst));
                end
            end
        end
    end

    task automatic testSingleOps();
        for (int b = 0; b < 3; b++) begin
            checkBit(wbHasResult[b], 1'b0, "wbHasResult after reset");
        end
        checkBit(exUop[0].valid, 1'b0, "lane 0 exUop valid after reset");
        checkBit(exUop[1].valid, 1'b0, "lane 1 exUop valid after reset");
        issue(0, FU_INT, ADD, 0, 0, 1, 1'b1, 1'b1, 32'h40, 1'b0);
        issue(1, FU_INT, LUI, 0, 0, 2, 1'b0, 1'b1, 32'hABCD_E000, 1'b0);
        tick();
        checkExUop(exUop[0], enableXU[0], wantEx[0], wantEn[0], "lane 0 ADD");
        checkExUop(exUop[1], enableXU[1], wantEx[1], wantEn[1], "lane 1 LUI");
        issue(0, FU_INT, SUB, 0, 0, 3, 1'b1, 1'b1, $random(seed), 1'b0);
        issue(1, FU_INT, AND, 0, 0, 4, 1'b1, 1'b1, $random(seed), 1'b0);
        tick();
        drain();
    endtask

    task automatic testChains();
        issue(0, FU_INT, ADD, 0, 0, 5, 1'b0, 1'b1, $random(seed), 1'b0);
        tick();
        issue(0, FU_INT, ADD, 5, 0, 6, 1'b0, 1'b1, $random(seed), 1'b0);
        issue(1, FU_INT, XOR, 5, 0, 7, 1'b0, 1'b1, $random(seed), 1'b0);
        tick();
        issue(0, FU_INT, SUB, 6, 7, 8, 1'b0, 1'b0, 32'h0, 1'b0);
        issue(1, FU_INT, SLL, 7, 6, 9, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        tick();
        // Sources sit on the writeback buses this cycle
        issue(0, FU_INT, SRA, 8, 9, 10, 1'b0, 1'b0, 32'h0, 1'b0);
        issue(1, FU_INT, SRL, 9, 8, 11, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        tick();
        tick();
        issue(0, FU_INT, SLT, 10, 11, 12, 1'b0, 1'b0, 32'h0, 1'b0);
        issue(1, FU_INT, SLTU, 11, 10, 13, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        drain();
    endtask

    task automatic testMultiply();
        issue(0, FU_INT, ADD, 0, 0, 14, 1'b0, 1'b1, $random(seed), 1'b0);
        issue(1, FU_INT, ADD, 0, 0, 15, 1'b0, 1'b1, $random(seed), 1'b0);
        tick();
        issue(1, FU_MUL, MUL_LO, 14, 15, 16, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        issue(1, FU_MUL, MUL_HI, 14, 15, 17, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        tick();
        tick();
        // Low word from the register file, high word from the writeback bus
        issue(0, FU_INT, ADD, 16, 17, 18, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        drain();
    endtask

    task automatic testLoadStore();
        SqN sq;
        sq = nextSqN;
        issue(0, FU_LSU, ADD, 14, 0, 20, 1'b0, 1'b1, 32'h40, 1'b0);
        tick();
        checkExUop(exUop[0], enableXU[0], wantEx[0], wantEn[0], "load/store micro-op");
        tick();
        injectLsu(20, $random(seed), sq);
        issue(1, FU_INT, ADD, 20, 14, 21, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        tick();
        tick();
        issue(0, FU_INT, XOR, 20, 21, 22, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        drain();
    endtask

    task automatic testStallAndFlush();
        SqN keep;
        issue(0, FU_LSU, OR, 14, 15, 23, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        wbStall[0] = 1'b1;
        repeat (3) begin
            tick();
            checkExUop(exUop[0], enableXU[0], wantEx[0], wantEn[0], "stalled lane 0");
        end
        flush(wantEx[0].sqN - 6'd1);
        tick();
        wantEx[0].valid = 1'b0;
        wantEn[0] = 3'b000;
        checkExUop(exUop[0], enableXU[0], wantEx[0], wantEn[0], "flushed stalled lane 0");
        wbStall[0] = 1'b0;

        // The younger lane 1 ALU op dies inside its integer unit
        keep = nextSqN;
        issue(0, FU_INT, ADD, 14, 0, 24, 1'b0, 1'b1, $random(seed), 1'b0);
        issue(1, FU_INT, ADD, 14, 15, 25, 1'b0, 1'b0, 32'h0, 1'b1);
        tick();
        issue(0, FU_INT, SUB, 24, 14, 26, 1'b0, 1'b0, 32'h0, 1'b1);
        issue(1, FU_INT, ADD, 15, 0, 27, 1'b0, 1'b1, 32'h5, 1'b1);
        flush(keep);
        tick();
        drain();

        // Older multiply in stage one survives while the younger one in Load dies
        keep = nextSqN;
        issue(1, FU_MUL, MUL_HI, 24, 15, 28, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        issue(1, FU_MUL, MUL_LO, 24, 14, 29, 1'b0, 1'b0, 32'h0, 1'b1);
        tick();
        flush(keep);
        tick();
        drain();

        issue(1, FU_MUL, MUL_LO, 24, 14, 30, 1'b0, 1'b0, 32'h0, 1'b1);
        tick();
        tick();
        flush(wantEx[1].sqN - 6'd1);
        tick();
        issue(0, FU_INT, ADD, 24, 28, 31, 1'b0, 1'b0, 32'h0, 1'b0);
        tick();
        drain();
    endtask

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        stopRun("Timeout: the tests did not finish within their cycle budget");
    end

    initial begin
        rst = 1'b1;
        invalidate = 1'b0;
        invalidateSqN = '0;
        lsuHasResult = 1'b0;
        lsuResult = '0;
        for (int i = 0; i < 2; i++) begin
            uopValid[i] = 1'b0;
            uop[i] = '0;
            wbStall[i] = 1'b0;
        end
        for (int t = 0; t < 64; t++) begin
            regVal[t] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        testSingleOps();
        testChains();
        testMultiply();
        testLoadStore();
        testStallAndFlush();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: uopPkg.sv
package uopPkg;

    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_MUL
    } FuncUnit;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI
    } AluOp;

    // Multiplier reuses the first two ALU encodings
    localparam AluOp MUL_LO = ADD;
    localparam AluOp MUL_HI = SUB;

    typedef struct packed {
        logic [31:0] imm;
        logic [31:0] pc;
        regPkg::SqN sqN;
        regPkg::Tag tagA;
        regPkg::Tag tagB;
        regPkg::Tag tagDst;
        logic [4:0] nmDst;
        AluOp opcode;
        FuncUnit fu;
        logic pcA;
        logic immB;
        regPkg::SqN loadSqN;
        regPkg::SqN storeSqN;
    } R_UOp;

    typedef struct packed {
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] imm;
        logic [31:0] pc;
        regPkg::SqN sqN;
        regPkg::Tag tagDst;
        logic [4:0] nmDst;
        AluOp opcode;
        regPkg::SqN loadSqN;
        regPkg::SqN storeSqN;
        logic valid;
    } EX_UOp;

endpackage
